//--- source/lcd_consts.svh
`ifndef LCD_CONSTS_SVH
`define LCD_CONSTS_SVH

// Write table size
`define LCD_TABLE_LEN 37	// Init commands, two text lines, line-2 address
`define LCD_LAST_INDEX 36	// Index wraps to 0 after this entry

// Clock cycles per tick
// 1 ms at 50 MHz, long enough for the clear command
`define LCD_TICK_DIV_DEFAULT 50000

// HD44780 command codes
`define LCD_CMD_FUNCSET 8'h38	// 8-bit bus, 2 lines, 5x8 font
`define LCD_CMD_ENTRY 8'h06	// Increment cursor, no shift
`define LCD_CMD_DISPON 8'h0C	// Display on, cursor off
`define LCD_CMD_CLEAR 8'h01	// Clear display, cursor home
`define LCD_CMD_LINE2 8'hC0	// DDRAM address 0x40

`endif

//--- source/lcd_pkg.sv
package lcd_pkg;

	// One byte on the LCD data bus
	// Either a command code or an ASCII character
	typedef logic [7:0] lcd_byte_t;

	// Position in the write table, 0 to 36
	typedef logic [5:0] lcd_index_t;

	// Phases of one bus write, one tick each
	typedef enum logic [1:0] {
		PH_SETUP  = 2'd0,	// Load rs and dat from the table
		PH_ENABLE = 2'd1,	// Raise the enable line
		PH_HOLD   = 2'd2	// Drop enable, then step the index
	} lcd_phase_t;

endpackage

//--- source/lcd_tick_gen.sv
module lcd_tick_gen #(
	parameter int TICK_DIV = 4
) (
	input  logic clk,
	input  logic arst_n,
	output logic tick
);

	// At least one bit, even for a divider of 1
	localparam int CNT_W = (TICK_DIV > 1) ? $clog2(TICK_DIV) : 1;
	localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(TICK_DIV - 1);

	logic [CNT_W-1:0] count;	// Free-running, 0 to TICK_DIV-1

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			count <= '0;
		end else if (count == CNT_LAST) begin
			count <= '0;	// Wrap, tick is high this cycle
		end else begin
			count <= count + 1'b1;
		end
	end

	// One cycle strobe on the last count
	assign tick = (count == CNT_LAST);

	// With a real divider the strobe never lasts two cycles
	a_tick_single: assert property (
		@(posedge clk) disable iff (!arst_n)
		(TICK_DIV > 1) && tick |=> !tick
	) else $error("tick high for two cycles in a row");

endmodule

//--- source/lcd_message_rom.sv
`include "lcd_consts.svh"

module lcd_message_rom (
	input  lcd_pkg::lcd_index_t index,
	output logic                rs_bit,
	output lcd_pkg::lcd_byte_t  data_byte
);

	import lcd_pkg::*;

	// Text is the common case, commands clear rs_bit
	always_comb begin
		rs_bit    = 1'b1;
		data_byte = `LCD_CMD_CLEAR;
		case (index)
			6'd0: begin
				rs_bit    = 1'b0;
				data_byte = `LCD_CMD_FUNCSET;
			end
			6'd1: begin
				rs_bit    = 1'b0;
				data_byte = `LCD_CMD_ENTRY;
			end
			6'd2: begin
				rs_bit    = 1'b0;
				data_byte = `LCD_CMD_DISPON;
			end
			6'd3: begin
				rs_bit    = 1'b0;
				data_byte = `LCD_CMD_CLEAR;
			end
			// Line 1, "LCD READY  8 BIT"
			6'd4:  data_byte = "L";
			6'd5:  data_byte = "C";
			6'd6:  data_byte = "D";
			6'd7:  data_byte = " ";
			6'd8:  data_byte = "R";
			6'd9:  data_byte = "E";
			6'd10: data_byte = "A";
			6'd11: data_byte = "D";
			6'd12: data_byte = "Y";
			6'd13: data_byte = " ";
			6'd14: data_byte = " ";
			6'd15: data_byte = "8";
			6'd16: data_byte = " ";
			6'd17: data_byte = "B";
			6'd18: data_byte = "I";
			6'd19: data_byte = "T";
			6'd20: begin
				rs_bit    = 1'b0;	// Cursor to start of line 2
				data_byte = `LCD_CMD_LINE2;
			end
			// Line 2, "HD44780 DRIVER  "
			6'd21: data_byte = "H";
			6'd22: data_byte = "D";
			6'd23: data_byte = "4";
			6'd24: data_byte = "4";
			6'd25: data_byte = "7";
			6'd26: data_byte = "8";
			6'd27: data_byte = "0";
			6'd28: data_byte = " ";
			6'd29: data_byte = "D";
			6'd30: data_byte = "R";
			6'd31: data_byte = "I";
			6'd32: data_byte = "V";
			6'd33: data_byte = "E";
			6'd34: data_byte = "R";
			6'd35: data_byte = " ";
			6'd36: data_byte = " ";
			default: begin
				rs_bit    = 1'b0;	// Past the table, harmless clear
				data_byte = `LCD_CMD_CLEAR;
			end
		endcase
	end

endmodule

//--- source/lcd_write_sequencer.sv
`include "lcd_consts.svh"

module lcd_write_sequencer (
	input  logic                clk,
	input  logic                arst_n,
	input  logic                tick,
	output lcd_pkg::lcd_index_t index,
	input  logic                rom_rs,
	input  lcd_pkg::lcd_byte_t  rom_byte,
	output logic                rs,
	output lcd_pkg::lcd_byte_t  dat,
	output logic                ena
);

	import lcd_pkg::*;

	localparam lcd_index_t LAST_INDEX = lcd_index_t'(`LCD_LAST_INDEX);

	lcd_phase_t phase;

	// Each write is three ticks long
	// rs and dat settle one tick before enable and hold one tick after it
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			phase <= PH_SETUP;
			index <= '0;
			ena   <= 1'b0;
			rs    <= 1'b0;
			dat   <= '0;
		end else if (tick) begin
			case (phase)
				PH_SETUP: begin
					rs    <= rom_rs;	// Latch table entry
					dat   <= rom_byte;
					phase <= PH_ENABLE;
				end
				PH_ENABLE: begin
					ena   <= 1'b1;
					phase <= PH_HOLD;
				end
				PH_HOLD: begin
					ena   <= 1'b0;	// Panel takes data on this edge
					phase <= PH_SETUP;
					if (index == LAST_INDEX) begin
						index <= '0;	// Start the table over
					end else begin
						index <= index + 1'b1;
					end
				end
				default: begin
					ena   <= 1'b0;
					phase <= PH_SETUP;
				end
			endcase
		end
	end

	// Enable is only driven during the hold phase
	a_ena_in_hold: assert property (
		@(posedge clk) disable iff (!arst_n)
		ena |-> (phase == PH_HOLD)
	) else $error("ena high outside PH_HOLD");

	// Bus must not move under the enable pulse or on its falling edge
	a_bus_stable: assert property (
		@(posedge clk) disable iff (!arst_n)
		ena |=> ($stable(dat) && $stable(rs))
	) else $error("dat or rs changed while ena was high");

	a_index_range: assert property (
		@(posedge clk) disable iff (!arst_n)
		index <= LAST_INDEX
	) else $error("index past the end of the table");

endmodule

//--- source/lcd_controller.sv
`include "lcd_consts.svh"

module lcd_controller #(
	parameter int TICK_DIV = `LCD_TICK_DIV_DEFAULT
) (
	input  logic               clk,
	input  logic               arst_n,
	output logic               rs,
	output logic               rw,
	output logic               ena,
	output lcd_pkg::lcd_byte_t dat
);

	import lcd_pkg::*;

	logic       tick;	// One cycle per TICK_DIV clocks
	lcd_index_t index;
	logic       rom_rs;
	lcd_byte_t  rom_byte;

	lcd_tick_gen #(
		.TICK_DIV (TICK_DIV)
	) i_tick_gen (
		.clk    (clk),
		.arst_n (arst_n),
		.tick   (tick)
	);

	lcd_write_sequencer i_sequencer (
		.clk      (clk),
		.arst_n   (arst_n),
		.tick     (tick),
		.index    (index),
		.rom_rs   (rom_rs),
		.rom_byte (rom_byte),
		.rs       (rs),
		.dat      (dat),
		.ena      (ena)
	);

	lcd_message_rom i_message_rom (
		.index     (index),
		.rs_bit    (rom_rs),
		.data_byte (rom_byte)
	);

	assign rw = 1'b0;	// Write only, busy flag never read

endmodule

//--- test/lcd_model.svh
`ifndef LCD_MODEL_SVH
`define LCD_MODEL_SVH

// Layout of the write table
localparam int LINE1_FIRST = 4;	// After the four init commands
localparam int LINE_LEN    = 16;
localparam int LINE2_ADDR  = LINE1_FIRST + LINE_LEN;
localparam int LINE2_FIRST = LINE2_ADDR + 1;

// First character sits in the top byte
localparam logic [8*LINE_LEN-1:0] LINE1_TEXT = "LCD READY  8 BIT";
localparam logic [8*LINE_LEN-1:0] LINE2_TEXT = "HD44780 DRIVER  ";

logic      exp_rs   [`LCD_TABLE_LEN];	// 0 for commands, 1 for text
lcd_byte_t exp_byte [`LCD_TABLE_LEN];

function automatic lcd_byte_t text_char(input logic [8*LINE_LEN-1:0] text, input int col);
	return text[8*(LINE_LEN-1-col) +: 8];
endfunction

// Fills the expected rs and byte for every table entry
task automatic load_expected_table();
	exp_rs[0]   = 1'b0;
	exp_byte[0] = `LCD_CMD_FUNCSET;
	exp_rs[1]   = 1'b0;
	exp_byte[1] = `LCD_CMD_ENTRY;
	exp_rs[2]   = 1'b0;
	exp_byte[2] = `LCD_CMD_DISPON;
	exp_rs[3]   = 1'b0;
	exp_byte[3] = `LCD_CMD_CLEAR;
	for (int col = 0; col < LINE_LEN; col++) begin
		exp_rs[LINE1_FIRST+col]   = 1'b1;
		exp_byte[LINE1_FIRST+col] = text_char(LINE1_TEXT, col);
		exp_rs[LINE2_FIRST+col]   = 1'b1;
		exp_byte[LINE2_FIRST+col] = text_char(LINE2_TEXT, col);
	end
	exp_rs[LINE2_ADDR]   = 1'b0;	// Cursor jump between the lines
	exp_byte[LINE2_ADDR] = `LCD_CMD_LINE2;
endtask

// Entry that follows pos, wrapping after the last one
function automatic int next_entry(input int pos);
	if (pos == `LCD_LAST_INDEX) begin
		return 0;
	end
	return pos + 1;
endfunction

`endif

//--- test/lcd_controller_tb.sv
`include "lcd_consts.svh"

module lcd_controller_tb;

	import lcd_pkg::*;

	`include "lcd_model.svh"

	localparam int TB_TICK_DIV   = 4;
	localparam int CLK_PERIOD    = 100;
	localparam int DRIVE_DELAY   = 10;	// After the rising edge
	localparam int RESET_CYCLES  = 3;
	localparam int INJECT_ROUNDS = 3;
	localparam int WRITE_CYCLES  = 3 * TB_TICK_DIV;
	localparam logic [31:0] LFSR_SEED = 32'hdea7;
	localparam logic [31:0] LFSR_TAPS = 32'h80200003;
	// Six full passes plus the longest wait and reset of every round
	localparam int WATCHDOG_TIME = (6 * 3 * `LCD_TABLE_LEN * TB_TICK_DIV
		+ INJECT_ROUNDS * (1024 + RESET_CYCLES + 1)) * CLK_PERIOD;

	logic      clk;
	logic      arst_n;
	logic      rs;
	logic      rw;
	logic      ena;
	lcd_byte_t dat;

	logic [31:0] lfsr_state;
	int          error_count   = 0;
	int          timing_errors = 0;
	int          check_count   = 0;
	int          tests_run     = 0;
	int          tests_failed  = 0;

	// Bus tracker state
	int        pulse_count  = 0;	// Never cleared by reset
	int        exp_index    = 0;
	int        high_len     = 0;
	int        since_change = 0;
	int        since_fall   = 1000;
	int        since_rise   = 0;
	logic      have_rise    = 1'b0;
	logic      bus_moved;
	logic      prev_ena     = 1'b0;
	logic      prev_rs      = 1'b0;
	lcd_byte_t prev_dat     = '0;
	logic      last_rs      = 1'b0;
	lcd_byte_t last_dat     = '0;

	lcd_controller #(
		.TICK_DIV (TB_TICK_DIV)
	) i_dut (
		.clk    (clk),
		.arst_n (arst_n),
		.rs     (rs),
		.rw     (rw),
		.ena    (ena),
		.dat    (dat)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	function automatic logic [31:0] lfsr_step(input logic [31:0] state);
		logic [31:0] next;
		next = state >> 1;
		if (state[0]) begin
			next = next ^ LFSR_TAPS;
		end
		return next;
	endfunction

	// One LFSR step per bit taken
	task automatic take_bits(input int count, output int unsigned value);
		value = 0;
		for (int i = 0; i < count; i++) begin
			lfsr_state = lfsr_step(lfsr_state);
			value = {value[30:0], lfsr_state[0]};
		end
	endtask

	task automatic check_value(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		check_count++;
		assert (actual === expected) else begin
			$display("[FAIL] %s expected 0x%0h got 0x%0h", name, expected, actual);
			error_count++;
		end
	endtask

	task automatic count_timing_error();
		timing_errors++;
		error_count++;
	endtask

	task automatic apply_reset(input int cycles);
		@(posedge clk);
		#DRIVE_DELAY arst_n = 1'b0;
		repeat (cycles) @(posedge clk);
		#DRIVE_DELAY arst_n = 1'b1;
	endtask

	task automatic wait_pulses(input int count);
		int target;
		target = pulse_count + count;
		while (pulse_count < target) @(posedge clk);
	endtask

	task automatic report_test(input string name, input int new_errors);
		tests_run++;
		if (new_errors == 0) begin
			$display("test %s: ok", name);
		end else begin
			tests_failed++;
			$display("test %s: %0d errors", name, new_errors);
		end
	endtask

	// Follows the bus on falling clock edges where all outputs are settled
	always @(negedge clk) begin
		check_value("rw", 32'd0, 32'(rw));
		if (!arst_n) begin
			check_value("ena", 32'd0, 32'(ena));
			check_value("rs", 32'd0, 32'(rs));
			check_value("dat", 32'd0, 32'(dat));
			exp_index    = 0;	// Table restarts at entry 0
			have_rise    = 1'b0;
			high_len     = 0;
			since_change = 0;
			since_fall   = 1000;
		end else begin
			bus_moved    = (rs !== prev_rs) || (dat !== prev_dat);
			since_change = bus_moved ? 0 : since_change + 1;
			since_fall++;
			since_rise++;
			assert (!(bus_moved && since_fall < TB_TICK_DIV)) else begin
				$display("rs or dat changed %0d cycles after ena fell", since_fall);
				count_timing_error();
			end
			assert (!(bus_moved && prev_ena)) else begin
				$display("rs or dat changed while ena was high");
				count_timing_error();
			end
			if (ena && !prev_ena) begin
				assert (since_change >= TB_TICK_DIV) else begin
					$display("rs or dat settled only %0d cycles before ena rose",
						since_change);
					count_timing_error();
				end
				assert (!have_rise || since_rise == WRITE_CYCLES) else begin
					$display("ena rose %0d cycles after the previous rise instead of %0d",
						since_rise, WRITE_CYCLES);
					count_timing_error();
				end
				check_value("rs", 32'(exp_rs[exp_index]), 32'(rs));
				check_value("dat", 32'(exp_byte[exp_index]), 32'(dat));
				have_rise  = 1'b1;
				since_rise = 0;
				high_len   = 0;
				last_rs    = rs;
				last_dat   = dat;
				pulse_count++;
			end
			if (ena) begin
				high_len++;
			end
			if (!ena && prev_ena) begin
				assert (high_len == TB_TICK_DIV) else begin
					$display("ena stayed high for %0d cycles instead of %0d",
						high_len, TB_TICK_DIV);
					count_timing_error();
				end
				exp_index  = next_entry(exp_index);	// Panel took this entry
				since_fall = 0;
			end
		end
		prev_ena = ena;
		prev_rs  = rs;
		prev_dat = dat;
	end

	initial begin
		#(WATCHDOG_TIME);
		$display("watchdog expired before the tests finished");
		$display("** FAIL **");
		$finish;
	end

	initial begin
		int          errs_at;
		int unsigned inject;
		int unsigned delay;
		int          injected;
		arst_n     = 1'b0;
		lfsr_state = LFSR_SEED;
		injected   = 0;
		load_expected_table();

		errs_at = error_count;
		repeat (RESET_CYCLES) @(posedge clk);
		#DRIVE_DELAY arst_n = 1'b1;
		repeat (TB_TICK_DIV) begin	// Outputs idle until the first tick
			@(negedge clk);
			check_value("ena", 32'd0, 32'(ena));
			check_value("rs", 32'd0, 32'(rs));
			check_value("dat", 32'd0, 32'(dat));
		end
		@(posedge clk);
		report_test("reset_values", error_count - errs_at);

		errs_at = error_count;
		wait_pulses(LINE1_FIRST);
		report_test("init_commands", error_count - errs_at);

		errs_at = error_count;
		wait_pulses(`LCD_TABLE_LEN - LINE1_FIRST);
		report_test("text_lines", error_count - errs_at);

		errs_at = error_count;
		wait_pulses(`LCD_TABLE_LEN);	// Second pass after the wrap
		report_test("wrap_second_pass", error_count - errs_at);

		report_test("bus_timing", timing_errors);

		errs_at = error_count;
		for (int round = 0; round < INJECT_ROUNDS; round++) begin
			take_bits(1, inject);
			if (inject != 0 || (round == INJECT_ROUNDS - 1 && injected == 0)) begin
				take_bits(10, delay);
				repeat (delay) @(posedge clk);
				apply_reset(RESET_CYCLES);
				injected++;
				wait_pulses(1);
				check_value("rs", 32'(exp_rs[0]), 32'(last_rs));
				check_value("dat", 32'(exp_byte[0]), 32'(last_dat));
				wait_pulses(`LCD_TABLE_LEN - 1);
			end else begin
				wait_pulses(`LCD_TABLE_LEN);
			end
		end
		report_test("reset_injection", error_count - errs_at);

		$display("tests run %0d, failed %0d, value checks %0d, errors %0d, resets injected %0d",
			tests_run, tests_failed, check_count, error_count, injected);
		if (error_count == 0 && tests_failed == 0) begin
			$display("** PASS **");
		end else begin
			$display("** FAIL **");
		end
		$finish;
	end

endmodule

//--- vlog.f
+incdir+source
+incdir+test
source/lcd_pkg.sv
source/lcd_tick_gen.sv
source/lcd_message_rom.sv
source/lcd_write_sequencer.sv
source/lcd_controller.sv
test/lcd_controller_tb.sv

//--- Makefile
TOP := lcd_controller_tb

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -j 0 -f vlog.f --top-module $(TOP) -o sim
	@out="$$(./obj_dir/sim)"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF '** PASS **'

clean:
	rm -rf obj_dir
